/* common/extBusPkg.sv */
package extBusPkg;

    // Word layout of the external bus, tag above data
    localparam int DATA_WIDTH = 64;
    localparam int TAG_WIDTH  = 8;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]  tag;  // Bits 71:64
        logic [DATA_WIDTH-1:0] data; // Bits 63:0
    } busWord_t;

    // Processor commands
    // Encodings 5..7 are reserved and flagged as illegal by the decoder
    typedef enum logic [2:0] {
        OP_NOP      = 3'd0, // No port activity
        OP_WRITE    = 3'd1, // Full word write on port A
        OP_READ     = 3'd2, // Data read on port B, tag returned as zero
        OP_READ_TAG = 3'd3, // Data and tag read on port B
        OP_PEEK     = 3'd4  // Full word read on port C
    } busOp_t;

    // Source of a processor response
    localparam logic RESP_PORT_B = 1'b0;
    localparam logic RESP_PORT_C = 1'b1;

endpackage

/* common/portCtrlIf.sv */
interface portCtrlIf #(
    parameter int ADDR_WIDTH = 2
);

    // Port A, processor write side
    logic                  enA;
    logic                  wrA;
    logic [ADDR_WIDTH-1:0] addrA;
    extBusPkg::busWord_t   dataA;

    // Port B, data read with separate tag enable
    logic                  enB;
    logic                  wrB;
    logic                  tagEnB;
    logic [ADDR_WIDTH-1:0] addrB;

    // Port C, full word read
    logic                  enC;
    logic                  wrC;
    logic [ADDR_WIDTH-1:0] addrC;

    // Port X, memory side
    logic                  enX;
    logic                  wrX;
    logic [ADDR_WIDTH-1:0] addrX;
    extBusPkg::busWord_t   dataX;

    // Returned read data, one cycle after the strobes
    extBusPkg::busWord_t   rdDataB;
    extBusPkg::busWord_t   rdDataC;
    extBusPkg::busWord_t   rdDataX;
    logic                  rdValidB;
    logic                  rdValidC;
    logic                  rdValidX;
    logic                  rdTagEnB;  // Tag enable aligned with rdDataB

    modport decodeMp (
        output enA, wrA, addrA, dataA,
        output enB, wrB, tagEnB, addrB,
        output enC, wrC, addrC,
        output enX, wrX, addrX, dataX
    );

    modport regsMp (
        input  enA, wrA, addrA, dataA,
        input  enB, wrB, tagEnB, addrB,
        input  enC, wrC, addrC,
        input  enX, wrX, addrX, dataX,
        output rdDataB, rdDataC, rdDataX,
        output rdValidB, rdValidC, rdValidX, rdTagEnB
    );

    modport resultMp (
        input  rdDataB, rdDataC, rdDataX,
        input  rdValidB, rdValidC, rdValidX, rdTagEnB
    );

endinterface

/* design/extBusTop.sv */
module extBusTop #(
    parameter int ADDR_WIDTH = 2
) (
    input  logic                                clk,
    input  logic                                rstN,

    // Processor command
    input  logic                                cmdValid,
    input  extBusPkg::busOp_t                   cmdOp,
    input  logic [ADDR_WIDTH-1:0]               cmdAddr,
    input  extBusPkg::busWord_t                 cmdData,
    output logic                                cmdIllegal,

    // Processor response
    output logic                                respValid,
    output logic                                respSrc,
    output logic [extBusPkg::DATA_WIDTH-1:0]    respData,
    output logic [extBusPkg::TAG_WIDTH-1:0]     respTag,

    // Memory side access
    input  logic                                memValid,
    input  logic                                memWrite,
    input  logic [ADDR_WIDTH-1:0]               memAddr,
    input  extBusPkg::busWord_t                 memData,
    output logic                                memRdValid,
    output extBusPkg::busWord_t                 memRdData
);

    portCtrlIf #(.ADDR_WIDTH(ADDR_WIDTH)) ctrlBus ();  // Decode to register file
    portCtrlIf #(.ADDR_WIDTH(ADDR_WIDTH)) readBus ();  // Register file to result

    busDecode #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) busDecode_inst (
        .clk        (clk),
        .rstN       (rstN),
        .cmdValid   (cmdValid),
        .cmdOp      (cmdOp),
        .cmdAddr    (cmdAddr),
        .cmdData    (cmdData),
        .memValid   (memValid),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .memData    (memData),
        .cmdIllegal (cmdIllegal),
        .ctrl       (ctrlBus.decodeMp)
    );

    extBusRegs #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) extBusRegs_inst (
        .clk        (clk),
        .rstN       (rstN),
        .ctrl       (ctrlBus.regsMp),
        .rd         (readBus.regsMp)
    );

    busResult #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) busResult_inst (
        .clk        (clk),
        .rstN       (rstN),
        .rd         (readBus.resultMp),
        .respValid  (respValid),
        .respSrc    (respSrc),
        .respData   (respData),
        .respTag    (respTag),
        .memRdValid (memRdValid),
        .memRdData  (memRdData)
    );

endmodule

/* extBus/busDecode.sv */
module busDecode #(
    parameter int ADDR_WIDTH = 2
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  cmdValid,
    input  extBusPkg::busOp_t     cmdOp,
    input  logic [ADDR_WIDTH-1:0] cmdAddr,
    input  extBusPkg::busWord_t   cmdData,
    input  logic                  memValid,
    input  logic                  memWrite,
    input  logic [ADDR_WIDTH-1:0] memAddr,
    input  extBusPkg::busWord_t   memData,
    output logic                  cmdIllegal,
    portCtrlIf.decodeMp           ctrl
);

    logic nextEnA;
    logic nextEnB;
    logic nextTagEnB;
    logic nextEnC;
    logic nextIllegal;

    // Each legal opcode selects exactly one processor port
    always_comb begin
        nextEnA     = 1'b0;
        nextEnB     = 1'b0;
        nextTagEnB  = 1'b0;
        nextEnC     = 1'b0;
        nextIllegal = 1'b0;
        if (cmdValid) begin
            case (cmdOp)
                extBusPkg::OP_NOP: begin
                end
                extBusPkg::OP_WRITE:    nextEnA = 1'b1;
                extBusPkg::OP_READ:     nextEnB = 1'b1;  // Tag chips stay disabled
                extBusPkg::OP_READ_TAG: begin
                    nextEnB    = 1'b1;
                    nextTagEnB = 1'b1;
                end
                extBusPkg::OP_PEEK:     nextEnC = 1'b1;
                default:                nextIllegal = 1'b1; // Reserved 5..7
            endcase
        end
    end

    // B and C are read-only ports here
    assign ctrl.wrB = 1'b0;
    assign ctrl.wrC = 1'b0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrl.enA    <= 1'b0;
            ctrl.wrA    <= 1'b0;
            ctrl.enB    <= 1'b0;
            ctrl.tagEnB <= 1'b0;
            ctrl.enC    <= 1'b0;
            ctrl.enX    <= 1'b0;
            ctrl.wrX    <= 1'b0;
            cmdIllegal  <= 1'b0;
        end else begin
            ctrl.enA    <= nextEnA;
            ctrl.wrA    <= nextEnA;                // A only ever writes
            ctrl.enB    <= nextEnB;
            ctrl.tagEnB <= nextTagEnB;
            ctrl.enC    <= nextEnC;
            ctrl.enX    <= memValid;
            ctrl.wrX    <= memValid && memWrite;   // Store, else load
            cmdIllegal  <= nextIllegal;
        end
    end

    // Addresses and write data, held while idle
    always_ff @(posedge clk) begin
        if (cmdValid) begin
            ctrl.addrA <= cmdAddr;
            ctrl.addrB <= cmdAddr;
            ctrl.addrC <= cmdAddr;
            ctrl.dataA <= cmdData;
        end
        if (memValid) begin
            ctrl.addrX <= memAddr;
            ctrl.dataX <= memData;
        end
    end

    // Register file relies on a single processor port per cycle
    aOneProcPort: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({ctrl.enA, ctrl.enB, ctrl.enC}))
        else $error("busDecode: more than one processor port enabled");

endmodule

/* extBus/busResult.sv */
module busResult #(
    parameter int ADDR_WIDTH = 2
) (
    input  logic                                clk,
    input  logic                                rstN,
    portCtrlIf.resultMp                         rd,
    output logic                                respValid,
    output logic                                respSrc,
    output logic [extBusPkg::DATA_WIDTH-1:0]    respData,
    output logic [extBusPkg::TAG_WIDTH-1:0]     respTag,
    output logic                                memRdValid,
    output extBusPkg::busWord_t                 memRdData
);

    // Address width only matters upstream, but it must be usable there
    if (ADDR_WIDTH < 1) begin : gBadAddrWidth
        $error("busResult: ADDR_WIDTH must be at least 1");
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            respValid  <= 1'b0;
            memRdValid <= 1'b0;
        end else begin
            respValid  <= rd.rdValidB || rd.rdValidC;
            memRdValid <= rd.rdValidX;
        end
    end

    // Processor response, C and B never overlap
    always_ff @(posedge clk) begin
        if (rd.rdValidC) begin
            respSrc  <= extBusPkg::RESP_PORT_C;
            respData <= rd.rdDataC.data;
            respTag  <= rd.rdDataC.tag;
        end else if (rd.rdValidB) begin
            respSrc  <= extBusPkg::RESP_PORT_B;
            respData <= rd.rdDataB.data;
            respTag  <= rd.rdTagEnB ? rd.rdDataB.tag : '0;  // Untagged view
        end
    end

    // Memory load path, independent of the processor side
    always_ff @(posedge clk) begin
        if (rd.rdValidX) begin
            memRdData <= rd.rdDataX;
        end
    end

    aOneSource: assert property (@(posedge clk) disable iff (!rstN)
        !(rd.rdValidB && rd.rdValidC))
        else $error("busResult: B and C read data valid together");

endmodule

/* extBus/extBusRegs.sv */
module extBusRegs #(
    parameter int ADDR_WIDTH = 2
) (
    input  logic      clk,
    input  logic      rstN,
    portCtrlIf.regsMp ctrl,
    portCtrlIf.regsMp rd
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    extBusPkg::busWord_t mem [DEPTH];

    logic rdB;
    logic rdC;
    logic rdX;

    // A port never reads, the others read when not writing
    assign rdB = ctrl.enB && !ctrl.wrB;
    assign rdC = ctrl.enC && !ctrl.wrC;
    assign rdX = ctrl.enX && !ctrl.wrX;

    // Word array, cleared so unwritten words read back as zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (ctrl.enA && ctrl.wrA) begin
                mem[ctrl.addrA] <= ctrl.dataA;
            end
            // Issued after A, so X wins on an address clash
            if (ctrl.enX && ctrl.wrX) begin
                mem[ctrl.addrX] <= ctrl.dataX;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rd.rdValidB <= 1'b0;
            rd.rdValidC <= 1'b0;
            rd.rdValidX <= 1'b0;
            rd.rdTagEnB <= 1'b0;
        end else begin
            rd.rdValidB <= rdB;
            rd.rdValidC <= rdC;
            rd.rdValidX <= rdX;
            rd.rdTagEnB <= rdB && ctrl.tagEnB;
        end
    end

    // Reads sample the array before this edge's writes land
    always_ff @(posedge clk) begin
        if (rdB) begin
            rd.rdDataB.data <= mem[ctrl.addrB].data;
            // Tag slices only drive when their own enable is set
            rd.rdDataB.tag  <= ctrl.tagEnB ? mem[ctrl.addrB].tag : '0;
        end
        if (rdC) begin
            rd.rdDataC <= mem[ctrl.addrC];  // Full word, tag included
        end
        if (rdX) begin
            rd.rdDataX <= mem[ctrl.addrX];
        end
    end

    aTagNeedsB: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.tagEnB |-> ctrl.enB)
        else $error("extBusRegs: B tag enable without B enable");

    aBReadOnly: assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl.enB && ctrl.wrB))
        else $error("extBusRegs: write strobe on port B");

endmodule

/* flist.f */
common/extBusPkg.sv
common/portCtrlIf.sv
extBus/busDecode.sv
extBus/extBusRegs.sv
extBus/busResult.sv
design/extBusTop.sv
sim/extBusTb.sv

/* run.sh */
#!/bin/sh
# Build and run the extBusTb simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module extBusTb \
    -f flist.f \
    -Mdir obj_dir

out=$(./obj_dir/VextBusTb) || true
echo "$out"

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1

/* sim/extBusTb.sv */
module extBusTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ADDR_WIDTH    = 2;
    localparam int DEPTH         = 2 ** ADDR_WIDTH;
    localparam int RANDOM_CYCLES = 400;
    // Reset, idle, zero reads, random and directed parts take about 430 cycles
    localparam int MAX_CYCLES    = RANDOM_CYCLES + 100;

    logic                                clk;
    logic                                rstN;
    logic                                cmdValid;
    extBusPkg::busOp_t                   cmdOp;
    logic [ADDR_WIDTH-1:0]               cmdAddr;
    extBusPkg::busWord_t                 cmdData;
    logic                                cmdIllegal;
    logic                                respValid;
    logic                                respSrc;
    logic [extBusPkg::DATA_WIDTH-1:0]    respData;
    logic [extBusPkg::TAG_WIDTH-1:0]     respTag;
    logic                                memValid;
    logic                                memWrite;
    logic [ADDR_WIDTH-1:0]               memAddr;
    extBusPkg::busWord_t                 memData;
    logic                                memRdValid;
    extBusPkg::busWord_t                 memRdData;

    // Expected results at issue time
    logic                                issRespValid;
    logic                                issRespSrc;
    logic [extBusPkg::DATA_WIDTH-1:0]    issRespData;
    logic [extBusPkg::TAG_WIDTH-1:0]     issRespTag;
    logic                                issMemRdValid;
    extBusPkg::busWord_t                 issMemRdData;
    logic                                issIllegal;

    logic                                dlyRespValid [3];
    logic                                dlyRespSrc [3];
    logic [extBusPkg::DATA_WIDTH-1:0]    dlyRespData [3];
    logic [extBusPkg::TAG_WIDTH-1:0]     dlyRespTag [3];
    logic                                dlyMemRdValid [3];
    extBusPkg::busWord_t                 dlyMemRdData [3];
    logic                                dlyIllegal [3];

    extBusPkg::busWord_t model [DEPTH];  // Reference word array

    integer seed;
    int     cycleCount = 0;
    int     respErrors = 0;
    int     memErrors = 0;
    int     illegalErrors = 0;

    extBusTop #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) extBusTop_inst (
        .clk        (clk),
        .rstN       (rstN),
        .cmdValid   (cmdValid),
        .cmdOp      (cmdOp),
        .cmdAddr    (cmdAddr),
        .cmdData    (cmdData),
        .cmdIllegal (cmdIllegal),
        .respValid  (respValid),
        .respSrc    (respSrc),
        .respData   (respData),
        .respTag    (respTag),
        .memValid   (memValid),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .memData    (memData),
        .memRdValid (memRdValid),
        .memRdData  (memRdData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Three stage delay lines matching decode, register file and result
    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 3; i++) begin
                dlyRespValid[i]  <= 1'b0;
                dlyMemRdValid[i] <= 1'b0;
                dlyIllegal[i]    <= 1'b0;
            end
        end else begin
            dlyRespValid[0]  <= issRespValid;
            dlyMemRdValid[0] <= issMemRdValid;
            dlyIllegal[0]    <= issIllegal;
            for (int i = 1; i < 3; i++) begin
                dlyRespValid[i]  <= dlyRespValid[i-1];
                dlyMemRdValid[i] <= dlyMemRdValid[i-1];
                dlyIllegal[i]    <= dlyIllegal[i-1];
            end
        end
        dlyRespSrc[0]   <= issRespSrc;
        dlyRespData[0]  <= issRespData;
        dlyRespTag[0]   <= issRespTag;
        dlyMemRdData[0] <= issMemRdData;
        for (int i = 1; i < 3; i++) begin
            dlyRespSrc[i]   <= dlyRespSrc[i-1];
            dlyRespData[i]  <= dlyRespData[i-1];
            dlyRespTag[i]   <= dlyRespTag[i-1];
            dlyMemRdData[i] <= dlyMemRdData[i-1];
        end
    end

    // Outputs only change on the rising edge and settle by the falling one
    aRespValid: assert property (@(negedge clk) disable iff (!rstN)
        respValid == dlyRespValid[2])
        else begin
            respErrors = respErrors + 1;
            $display("ERR %0t respValid: expected %0b actual %0b",
                     $time, dlyRespValid[2], respValid);
        end

    aRespSrc: assert property (@(negedge clk) disable iff (!rstN)
        !dlyRespValid[2] || respSrc == dlyRespSrc[2])
        else begin
            respErrors = respErrors + 1;
            $display("ERR %0t respSrc: expected %0b actual %0b",
                     $time, dlyRespSrc[2], respSrc);
        end

    aRespData: assert property (@(negedge clk) disable iff (!rstN)
        !dlyRespValid[2] || respData == dlyRespData[2])
        else begin
            respErrors = respErrors + 1;
            $display("ERR %0t respData: expected %h actual %h",
                     $time, dlyRespData[2], respData);
        end

    aRespTag: assert property (@(negedge clk) disable iff (!rstN)
        !dlyRespValid[2] || respTag == dlyRespTag[2])
        else begin
            respErrors = respErrors + 1;
            $display("ERR %0t respTag: expected %h actual %h",
                     $time, dlyRespTag[2], respTag);
        end

    aMemRdValid: assert property (@(negedge clk) disable iff (!rstN)
        memRdValid == dlyMemRdValid[2])
        else begin
            memErrors = memErrors + 1;
            $display("ERR %0t memRdValid: expected %0b actual %0b",
                     $time, dlyMemRdValid[2], memRdValid);
        end

    aMemRdData: assert property (@(negedge clk) disable iff (!rstN)
        !dlyMemRdValid[2] || memRdData == dlyMemRdData[2])
        else begin
            memErrors = memErrors + 1;
            $display("ERR %0t memRdData: expected %h actual %h",
                     $time, dlyMemRdData[2], memRdData);
        end

    aCmdIllegal: assert property (@(negedge clk) disable iff (!rstN)
        cmdIllegal == dlyIllegal[0])
        else begin
            illegalErrors = illegalErrors + 1;
            $display("ERR %0t cmdIllegal: expected %0b actual %0b",
                     $time, dlyIllegal[0], cmdIllegal);
        end

    // Drives one cycle and predicts its results from the model
    task automatic issueCycle(
        input logic                  cValid,
        input logic [2:0]            opBits,
        input logic [ADDR_WIDTH-1:0] cAddr,
        input extBusPkg::busWord_t   cData,
        input logic                  mValid,
        input logic                  mWrite,
        input logic [ADDR_WIDTH-1:0] mAddr,
        input extBusPkg::busWord_t   mData
    );
        extBusPkg::busOp_t   op;
        extBusPkg::busWord_t cmdWord;
        logic                isRead;
        op      = extBusPkg::busOp_t'(opBits);
        cmdWord = model[cAddr];  // Old contents without same cycle writes
        isRead  = cValid && (op == extBusPkg::OP_READ || op == extBusPkg::OP_READ_TAG ||
                             op == extBusPkg::OP_PEEK);
        @(posedge clk);
        cmdValid      <= cValid;
        cmdOp         <= op;
        cmdAddr       <= cAddr;
        cmdData       <= cData;
        memValid      <= mValid;
        memWrite      <= mWrite;
        memAddr       <= mAddr;
        memData       <= mData;
        issRespValid  <= isRead;
        issRespSrc    <= (op == extBusPkg::OP_PEEK) ? extBusPkg::RESP_PORT_C
                                                    : extBusPkg::RESP_PORT_B;
        issRespData   <= cmdWord.data;
        issRespTag    <= (op == extBusPkg::OP_READ) ? '0 : cmdWord.tag;  // Untagged read
        issIllegal    <= cValid && (opBits > 3'd4);
        issMemRdValid <= mValid && !mWrite;
        issMemRdData  <= model[mAddr];
        if (cValid && op == extBusPkg::OP_WRITE) begin
            model[cAddr] = cData;
        end
        if (mValid && mWrite) begin
            model[mAddr] = mData;  // X applied last wins a clash
        end
    endtask

    task automatic idleCycles(input int count);
        for (int i = 0; i < count; i++) begin
            issueCycle(1'b0, 3'd0, '0, '0, 1'b0, 1'b0, '0, '0);
        end
    endtask

    function automatic extBusPkg::busWord_t randomWord();
        logic [31:0] hi;
        logic [31:0] lo;
        logic [31:0] tg;
        hi = $random(seed);
        lo = $random(seed);
        tg = $random(seed);
        return {tg[extBusPkg::TAG_WIDTH-1:0], hi, lo};
    endfunction

    task automatic randomCycle();
        logic [31:0]           ctl;
        logic [31:0]           addrs;
        logic                  cValid;
        logic [2:0]            opBits;
        logic                  mValid;
        logic                  mWrite;
        logic [ADDR_WIDTH-1:0] cAddr;
        logic [ADDR_WIDTH-1:0] mAddr;
        ctl    = $random(seed);
        addrs  = $random(seed);
        cValid = (ctl[1:0] != 2'd0);
        mValid = (ctl[9:8] != 2'd0);
        mWrite = ctl[10];
        cAddr  = addrs[ADDR_WIDTH-1:0];
        mAddr  = addrs[ADDR_WIDTH+15:16];
        case (ctl[7:4])
            4'd0, 4'd1, 4'd2:    opBits = extBusPkg::OP_WRITE;
            4'd3, 4'd4, 4'd5:    opBits = extBusPkg::OP_READ;
            4'd6, 4'd7, 4'd8:    opBits = extBusPkg::OP_READ_TAG;
            4'd9, 4'd10, 4'd11:  opBits = extBusPkg::OP_PEEK;
            4'd12:               opBits = extBusPkg::OP_NOP;
            default:             opBits = {1'b1, ctl[5:4]};  // Reserved 5..7
        endcase
        // Force an A and X write clash now and then
        if (ctl[13:11] == 3'd0) begin
            cValid = 1'b1;
            opBits = extBusPkg::OP_WRITE;
            mValid = 1'b1;
            mWrite = 1'b1;
            mAddr  = cAddr;
        end
        issueCycle(cValid, opBits, cAddr, randomWord(), mValid, mWrite, mAddr, randomWord());
    endtask

    task automatic tagMaskSequence();
        extBusPkg::busWord_t wordA;
        extBusPkg::busWord_t wordX;
        wordA = {8'hA5, 64'h0123_4567_89AB_CDEF};
        wordX = {8'h3C, 64'hFEDC_BA98_7654_3210};
        issueCycle(1'b1, extBusPkg::OP_WRITE, 2'd1, wordA, 1'b0, 1'b0, '0, '0);
        issueCycle(1'b1, extBusPkg::OP_READ, 2'd1, '0, 1'b1, 1'b0, 2'd1, '0);
        issueCycle(1'b1, extBusPkg::OP_READ_TAG, 2'd1, '0, 1'b0, 1'b0, '0, '0);
        issueCycle(1'b1, extBusPkg::OP_PEEK, 2'd1, '0, 1'b0, 1'b0, '0, '0);
        // Store on X next to a tagged read of the same word
        issueCycle(1'b1, extBusPkg::OP_READ_TAG, 2'd2, '0, 1'b1, 1'b1, 2'd2, wordX);
        issueCycle(1'b1, extBusPkg::OP_READ_TAG, 2'd2, '0, 1'b0, 1'b0, '0, '0);
        issueCycle(1'b1, extBusPkg::OP_READ, 2'd2, '0, 1'b0, 1'b0, '0, '0);
        issueCycle(1'b1, extBusPkg::OP_WRITE, 2'd3, wordA, 1'b1, 1'b1, 2'd3, wordX);
        issueCycle(1'b1, extBusPkg::OP_PEEK, 2'd3, '0, 1'b1, 1'b0, 2'd3, '0);
        issueCycle(1'b1, 3'd6, 2'd3, wordA, 1'b0, 1'b0, '0, '0);
        issueCycle(1'b1, extBusPkg::OP_READ_TAG, 2'd3, '0, 1'b0, 1'b0, '0, '0);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        seed          = 36536;
        rstN          = 1'b0;
        cmdValid      = 1'b0;
        cmdOp         = extBusPkg::OP_NOP;
        cmdAddr       = '0;
        cmdData       = '0;
        memValid      = 1'b0;
        memWrite      = 1'b0;
        memAddr       = '0;
        memData       = '0;
        issRespValid  = 1'b0;
        issRespSrc    = 1'b0;
        issRespData   = '0;
        issRespTag    = '0;
        issMemRdValid = 1'b0;
        issMemRdData  = '0;
        issIllegal    = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        idleCycles(2);
        // Unwritten words read back as zero on every port
        for (int a = 0; a < DEPTH; a++) begin
            issueCycle(1'b1, extBusPkg::OP_PEEK, a[ADDR_WIDTH-1:0], '0,
                       1'b1, 1'b0, a[ADDR_WIDTH-1:0], '0);
            issueCycle(1'b1, extBusPkg::OP_READ_TAG, a[ADDR_WIDTH-1:0], '0,
                       1'b0, 1'b0, '0, '0);
        end
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            randomCycle();
        end
        tagMaskSequence();
        idleCycles(4);
        @(negedge clk);
        $display("Errors: response %0d, memory %0d, illegal %0d",
                 respErrors, memErrors, illegalErrors);
        if (respErrors + memErrors + illegalErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
